// File: pitch_lag.f
logic/pitch_lag_pkg.sv
logic/sample_bus_if.sv
logic/frame_collector.sv
logic/sample_ram.sv
logic/lag_search.sv
logic/pitch_lag_top.sv
tests/pitch_lag_checker.sv
tests/tb_pitch_lag.sv

// File: run_sim.sh
#!/bin/sh
# builds the pitch lag testbench with Verilator and runs it
# the exit status of the simulation is the exit status of this script
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pitch_lag \
	-f pitch_lag.f

./obj_dir/Vtb_pitch_lag

// File: tests/tb_pitch_lag.sv
`timescale 1ns/1ps

module tb_pitch_lag import pitch_lag_pkg::*; ();

	logic clk;
	logic reset;
	logic sample_valid;
	logic signed [SAMPLE_W-1:0] sample;
	logic frame_ready;
	logic busy;
	logic done;
	logic [LAG_W-1:0] best_lag;
	logic signed [ACC_W-1:0] best_corr;
	logic signed [ACC_W-1:0] energy;

	int hist[$]; // every sample sent since reset
	int wr_cnt;
	logic fr_exp;
	logic seen_frame;

	logic [LAG_W-1:0] exp_lag;
	logic signed [ACC_W-1:0] exp_corr;
	logic signed [ACC_W-1:0] exp_energy;

	pitch_lag_top i_pitch_lag_top (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.frame_ready  (frame_ready),
		.busy         (busy),
		.done         (done),
		.best_lag     (best_lag),
		.best_corr    (best_corr),
		.energy       (energy)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic report_mismatch(input string name, input longint expected,
		input longint actual);
		stop_on_error($sformatf("Mismatch at %0t: %s expected %0d, actual %0d",
			$time, name, expected, actual));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	// doubled product, then clamp to the signed 32-bit range
	function automatic longint mac_ref(input longint acc, input int a, input int b);
		longint sum;
		sum = acc + 2 * longint'(a) * longint'(b);
		if (sum > longint'(MAX_32))
			return longint'(MAX_32);
		if (sum < longint'(MIN_32))
			return longint'(MIN_32);
		return sum;
	endfunction

	task automatic compute_expected();
		int s;
		int best;
		longint acc;
		longint max_acc;
		s = hist.size() - L_FRAME; // first sample of the newest frame
		best = LAG_MAX;
		max_acc = longint'(MIN_32);
		for (int lag = LAG_MAX; lag >= LAG_MIN; lag--)
		begin
			acc = 0;
			for (int n = 0; n < L_FRAME; n++)
				acc = mac_ref(acc, hist[s + n], hist[s + n - lag]);
			if (acc >= max_acc) // smaller lag wins a tie
			begin
				max_acc = acc;
				best = lag;
			end
		end
		acc = 0;
		for (int n = 0; n < L_FRAME; n++)
			acc = mac_ref(acc, hist[s + n - best], hist[s + n - best]);
		exp_lag = LAG_W'(best);
		exp_corr = ACC_W'(max_acc);
		exp_energy = ACC_W'(acc);
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	function automatic int next_sample(input string mode, input int idx);
		int v;
		v = 0;
		if (mode == "periodic")
		begin
			v = int'($urandom % 65) - 32; // small noise
			if (idx % 57 < 3)
				v = v + 9000; // pulse train, period 57
		end
		else if (mode == "random")
			v = int'($urandom % 2001) - 1000;
		else if (mode == "full_scale")
			v = 32767;
		return v;
	endfunction

	task automatic send_samples(input int count, input string mode);
		int v;
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			v = next_sample(mode, hist.size());
			sample_valid <= 1'b1;
			sample <= SAMPLE_W'(v);
			hist.push_back(v);
		end
		@(posedge clk);
		sample_valid <= 1'b0;
		sample <= '0;
	endtask

	task automatic wait_frame_ready(input int limit);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit)
		begin
			@(posedge clk);
			seen = frame_ready;
			cycles++;
		end
		if (!seen)
			stop_on_error("Timeout: no frame_ready after a complete frame was written");
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit)
		begin
			@(posedge clk);
			seen = done;
			cycles++;
		end
		if (!seen)
			stop_on_error("Timeout: the search never raised done");
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	task automatic expect_result(input logic [LAG_W-1:0] lag,
		input logic signed [ACC_W-1:0] corr, input logic signed [ACC_W-1:0] eng);
		assert (best_lag == lag) else report_mismatch("best_lag", lag, best_lag);
		assert (best_corr == corr) else report_mismatch("best_corr", corr, best_corr);
		assert (energy == eng) else report_mismatch("energy", eng, energy);
	endtask

	task automatic check_reset_state();
		assert (!busy) else report_mismatch("busy", 0, busy);
		assert (!done) else report_mismatch("done", 0, done);
		assert (!frame_ready) else report_mismatch("frame_ready", 0, frame_ready);
		expect_result('0, '0, '0);
	endtask

	task automatic run_frame(input string mode);
		send_samples(L_FRAME, mode);
		wait_frame_ready(4);
		compute_expected();
		// one step per lag and sample plus the energy pass, with margin
		wait_done((LAG_MAX - LAG_MIN + 2) * (3 * L_FRAME + 1) + 16);
		expect_result(exp_lag, exp_corr, exp_energy); // in the done cycle
	endtask

	// frame strobe timing, and quiet outputs before the first frame
	always @(posedge clk)
	begin
		if (reset)
		begin
			wr_cnt = 0;
			fr_exp = 1'b0;
			seen_frame = 1'b0;
		end
		else
		begin
			assert (frame_ready == fr_exp)
				else report_mismatch("frame_ready", fr_exp, frame_ready);
			if (frame_ready)
				seen_frame = 1'b1;
			if (!seen_frame)
				assert (!busy && !done)
					else stop_on_error("busy or done went high before the first frame_ready");
			fr_exp = sample_valid && ((wr_cnt + 1) % L_FRAME == 0) && (wr_cnt + 1 >= HISTORY);
			if (sample_valid)
				wr_cnt++;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		void'($urandom(79252));
		reset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_reset_state();

		send_samples(HISTORY - HISTORY % L_FRAME, "periodic"); // history only, no frame yet
		repeat (2) run_frame("periodic");
		repeat (4) run_frame("random"); // write pointer wraps here

		repeat (5) run_frame("zero");
		expect_result(LAG_W'(LAG_MIN), '0, '0);

		repeat (5) run_frame("full_scale");
		expect_result(LAG_W'(LAG_MIN), MAX_32, MAX_32);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: tests/pitch_lag_checker.sv
`timescale 1ns/1ps

module pitch_lag_checker import pitch_lag_pkg::*; (
	input logic clk,
	input logic reset,
	input logic frame_ready,
	input logic busy,
	input logic done,
	input logic [LAG_W-1:0] best_lag
);

	//////////////////////////////////////////////////
	// done and busy
	//////////////////////////////////////////////////
	done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	busy_low_at_done: assert property (@(posedge clk) disable iff (reset)
		done |-> !busy)
		else $error("busy still high while done is high");

	busy_falls_with_done: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> done)
		else $error("busy fell without a done pulse");

	//////////////////////////////////////////////////
	// frame strobe
	//////////////////////////////////////////////////
	// source waits for done, so no frame lands on a running search
	no_frame_while_busy: assert property (@(posedge clk) disable iff (reset)
		frame_ready |-> !busy)
		else $error("frame_ready arrived while a search was running");

	busy_after_frame: assert property (@(posedge clk) disable iff (reset)
		frame_ready |=> busy)
		else $error("busy did not rise after frame_ready");

	lag_in_range: assert property (@(posedge clk) disable iff (reset)
		done |-> (best_lag >= LAG_MIN && best_lag <= LAG_MAX))
		else $error("best_lag outside the searched lag range");

endmodule

bind pitch_lag_top pitch_lag_checker i_pitch_lag_checker (
	.clk         (clk),
	.reset       (reset),
	.frame_ready (frame_ready),
	.busy        (busy),
	.done        (done),
	.best_lag    (best_lag)
);

// File: logic/pitch_lag_top.sv
`timescale 1ns/1ps

module pitch_lag_top import pitch_lag_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic signed [SAMPLE_W-1:0] sample,
	output logic frame_ready,
	output logic busy,
	output logic done,
	output logic [LAG_W-1:0] best_lag,
	output logic signed [ACC_W-1:0] best_corr,
	output logic signed [ACC_W-1:0] energy
);

	logic [ADDR_W-1:0] frame_base;

	sample_bus_if bus ();

	//////////////////////////////////////////////////
	// producer, buffer, consumer
	//////////////////////////////////////////////////
	frame_collector i_frame_collector (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.mem          (bus.writer),
		.frame_ready  (frame_ready),
		.frame_base   (frame_base)
	);

	sample_ram i_sample_ram (
		.clk (clk),
		.mem (bus.memory)
	);

	lag_search i_lag_search (
		.clk         (clk),
		.reset       (reset),
		.frame_ready (frame_ready),
		.frame_base  (frame_base),
		.mem         (bus.reader),
		.busy        (busy),
		.done        (done),
		.best_lag    (best_lag),
		.best_corr   (best_corr),
		.energy      (energy)
	);

endmodule

// File: logic/lag_search.sv
`timescale 1ns/1ps

module lag_search import pitch_lag_pkg::*; (
	input logic clk,
	input logic reset,
	input logic frame_ready,
	input logic [ADDR_W-1:0] frame_base,
	sample_bus_if.reader mem,
	output logic busy,
	output logic done,
	output logic [LAG_W-1:0] best_lag,
	output logic signed [ACC_W-1:0] best_corr,
	output logic signed [ACC_W-1:0] energy
);

	logic [ST_W-1:0] state;
	logic [FCNT_W-1:0] n;
	logic [LAG_W-1:0] lag;
	logic energy_phase; // second pass over x[n-best]

	logic [ADDR_W-1:0] base;
	logic signed [SAMPLE_W-1:0] xa;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] max_corr;
	logic [LAG_W-1:0] best;

	logic [LAG_W-1:0] delay;
	logic [ADDR_W-1:0] cur_addr;

	//////////////////////////////////////////////////
	// saturating multiply-accumulate
	//////////////////////////////////////////////////
	function automatic logic signed [ACC_W-1:0] mac_sat(
		input logic signed [ACC_W-1:0] acc_in,
		input logic signed [SAMPLE_W-1:0] a,
		input logic signed [SAMPLE_W-1:0] b
	);
		logic signed [ACC_W-1:0] prod;
		logic [ACC_W+1:0] sum;
		logic [2:0] top;
		prod = a * b; // fits, |a*b| <= 2^30
		// two guard bits hold acc plus doubled product
		sum = {{2{acc_in[ACC_W-1]}}, acc_in} + {prod[ACC_W-1], prod, 1'b0};
		top = sum[ACC_W+1:ACC_W-1];
		if (top == 3'b000 || top == 3'b111)
			return sum[ACC_W-1:0];
		else if (sum[ACC_W+1])
			return MIN_32;
		else
			return MAX_32;
	endfunction

	//////////////////////////////////////////////////
	// read address
	//////////////////////////////////////////////////
	always_comb
	begin
		delay = energy_phase ? best : lag;
		cur_addr = base + ADDR_W'(n);
		// x[n] first during the correlation, x[n-delay] otherwise
		if (state == ST_RD0 && !energy_phase)
			mem.raddr = cur_addr;
		else
			mem.raddr = cur_addr - ADDR_W'(delay);
	end

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			n <= '0;
			lag <= '0;
			energy_phase <= 1'b0;
			best_lag <= '0;
			best_corr <= '0;
			energy <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (frame_ready) // ignored while a search runs
					begin
						busy <= 1'b1;
						lag <= LAG_W'(LAG_MAX);
						n <= '0;
						energy_phase <= 1'b0;
						state <= ST_RD0;
					end
				end
				ST_RD0:
					state <= ST_RD1;
				ST_RD1:
					state <= ST_MAC;
				ST_MAC:
				begin
					if (n == FCNT_W'(L_FRAME - 1))
					begin
						n <= '0;
						state <= energy_phase ? ST_DONE : ST_CMP;
					end
					else
					begin
						n <= n + 1'b1;
						state <= ST_RD0;
					end
				end
				ST_CMP:
				begin
					if (lag == LAG_W'(LAG_MIN))
						energy_phase <= 1'b1; // scan finished
					else
						lag <= lag - 1'b1;
					state <= ST_RD0;
				end
				ST_DONE:
				begin
					best_lag <= best;
					best_corr <= max_corr;
					energy <= acc;
					done <= 1'b1;
					busy <= 1'b0;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		case (state)
			ST_IDLE:
			begin
				if (frame_ready)
				begin
					base <= frame_base;
					acc <= '0;
					max_corr <= MIN_32;
					best <= LAG_W'(LAG_MAX);
				end
			end
			ST_RD1:
				xa <= mem.rdata; // word read in ST_RD0
			ST_MAC:
				acc <= mac_sat(acc, xa, mem.rdata);
			ST_CMP:
			begin
				// >= so the smaller lag wins a tie
				if (acc >= max_corr)
				begin
					max_corr <= acc;
					best <= lag;
				end
				acc <= '0;
			end
			default:
			begin
			end
		endcase
	end

endmodule

// File: logic/sample_ram.sv
`timescale 1ns/1ps

module sample_ram import pitch_lag_pkg::*; (
	input logic clk,
	sample_bus_if.memory mem
);

	logic signed [SAMPLE_W-1:0] store [DEPTH];

	//////////////////////////////////////////////////
	// write port and registered read port
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (mem.we)
			store[mem.waddr] <= mem.wdata;
	end

	// same address in one cycle returns the old word
	always_ff @(posedge clk)
	begin
		mem.rdata <= store[mem.raddr];
	end

endmodule

// File: logic/frame_collector.sv
`timescale 1ns/1ps

module frame_collector import pitch_lag_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic signed [SAMPLE_W-1:0] sample,
	sample_bus_if.writer mem,
	output logic frame_ready,
	output logic [ADDR_W-1:0] frame_base
);

	logic [ADDR_W-1:0] wptr;
	logic [FCNT_W-1:0] fcnt;
	logic [HCNT_W-1:0] hist_cnt;
	logic frame_end;
	logic hist_full;

	// samples go straight into the ram at the current pointer
	assign mem.we = sample_valid;
	assign mem.waddr = wptr;
	assign mem.wdata = sample;

	assign frame_end = sample_valid && (fcnt == FCNT_W'(L_FRAME - 1));
	assign hist_full = hist_cnt >= HCNT_W'(HISTORY - 1); // counts this write too

	//////////////////////////////////////////////////
	// pointers and counters
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wptr <= '0;
			fcnt <= '0;
			hist_cnt <= '0;
			frame_ready <= 1'b0;
		end
		else
		begin
			frame_ready <= 1'b0;
			if (sample_valid)
			begin
				wptr <= wptr + 1'b1; // wraps at DEPTH
				if (hist_cnt != HCNT_W'(HISTORY))
					hist_cnt <= hist_cnt + 1'b1;
				if (frame_end)
				begin
					fcnt <= '0;
					frame_ready <= hist_full;
				end
				else
				begin
					fcnt <= fcnt + 1'b1;
				end
			end
		end
	end

	// first sample of the frame just completed
	always_ff @(posedge clk)
	begin
		if (frame_end)
			frame_base <= wptr - ADDR_W'(L_FRAME - 1);
	end

endmodule

// File: logic/sample_bus_if.sv
`timescale 1ns/1ps

interface sample_bus_if import pitch_lag_pkg::*; ();

	logic we;
	logic [ADDR_W-1:0] waddr;
	logic signed [SAMPLE_W-1:0] wdata;
	logic [ADDR_W-1:0] raddr;
	logic signed [SAMPLE_W-1:0] rdata; // one clock after raddr

	modport writer (
		output we,
		output waddr,
		output wdata
	);

	modport memory (
		input we,
		input waddr,
		input wdata,
		input raddr,
		output rdata
	);

	modport reader (
		output raddr,
		input rdata
	);

endinterface

// File: logic/pitch_lag_pkg.sv
package pitch_lag_pkg;

	//////////////////////////////////////////////////
	// frame and lag range
	//////////////////////////////////////////////////
	localparam int L_FRAME = 40;
	localparam int LAG_MIN = 20;
	localparam int LAG_MAX = 143;
	localparam int HISTORY = LAG_MAX + L_FRAME; // samples needed before first frame

	//////////////////////////////////////////////////
	// widths and memory
	//////////////////////////////////////////////////
	localparam int ADDR_W = 8;
	localparam int DEPTH = 256; // at least LAG_MAX + L_FRAME
	localparam int SAMPLE_W = 16;
	localparam int ACC_W = 32;
	localparam int LAG_W = 8;
	localparam int FCNT_W = $clog2(L_FRAME);
	localparam int HCNT_W = $clog2(HISTORY + 1);

	localparam logic signed [ACC_W-1:0] MAX_32 = {1'b0, {(ACC_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] MIN_32 = {1'b1, {(ACC_W-1){1'b0}}};

	// search fsm encoding
	localparam int ST_W = 3;
	localparam logic [ST_W-1:0] ST_IDLE = ST_W'(0);
	localparam logic [ST_W-1:0] ST_RD0 = ST_W'(1);
	localparam logic [ST_W-1:0] ST_RD1 = ST_W'(2);
	localparam logic [ST_W-1:0] ST_MAC = ST_W'(3);
	localparam logic [ST_W-1:0] ST_CMP = ST_W'(4);
	localparam logic [ST_W-1:0] ST_DONE = ST_W'(5);

endpackage
